// File: radio_cfg_pkg.sv
package radio_cfg_pkg;

  // --------------------------------------------------
  // Clock and datapath widths
  // --------------------------------------------------

  // Number of external receivers fed by the core
  localparam int NUM_RX = 4;

  // NCO phase increment width
  localparam int PHASE_W = 32;
  typedef logic [PHASE_W-1:0] phase_word_t;

  // TX baseband samples are signed
  localparam int SAMPLE_W = 16;
  typedef logic signed [SAMPLE_W-1:0] tx_sample_t;

  // Upstream receiver words
  localparam int RX_W = 24;
  typedef logic [RX_W-1:0] rx_word_t;

  // Frequency to phase conversion for a 76.8 MHz clock
  // Multiplier is 2^57 over the clock, rounded at bit 24
  localparam logic [31:0] FREQ_MULT  = 32'd1876499845;
  localparam logic [31:0] FREQ_ROUND = 32'd16777216;
  localparam int          FREQ_MSB   = 56;
  localparam int          FREQ_LSB   = 25;

  // Decimation for 48 ksps, halved per rate step
  typedef logic [5:0] rate_t;
  localparam rate_t RATE48 = 6'd40;

  // Carrier levels for CW and VNA
  typedef logic [18:0] cw_level_t;
  localparam cw_level_t   MAX_CW_LEVEL = 19'h4d800;
  localparam logic [15:0] VNA_LEVEL    = 16'h4d80;

  // Keyer and serializer states
  typedef enum logic [1:0] {CW_RX, CW_RISE, CW_FALL} cw_state_e;
  typedef enum logic [1:0] {RXUS_IDLE, RXUS_I, RXUS_Q} rxus_state_e;

endpackage

// File: radio_cmd_pkg.sv
package radio_cmd_pkg;

  // --------------------------------------------------
  // Command slave port
  // --------------------------------------------------

  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;

  // Register addresses decoded by the core
  typedef enum logic [CMD_ADDR_W-1:0] {
    CMD_CTRL     = 6'h00,
    CMD_TX_FREQ  = 6'h01,
    CMD_RX0_FREQ = 6'h02,
    CMD_RX1_FREQ = 6'h03,
    CMD_RX2_FREQ = 6'h04,
    CMD_RX3_FREQ = 6'h05,
    CMD_VNA      = 6'h09
  } cmd_addr_e;

  // Idle plus three steps of the frequency multiply
  typedef enum logic [1:0] {CMD_IDLE, CMD_FREQ1, CMD_FREQ2, CMD_FREQ3} cmd_state_e;

  // Field positions inside the control words
  localparam int RATE_MSB      = 25;
  localparam int RATE_LSB      = 24;
  localparam int VNA_BIT       = 23;
  localparam int LAST_CHAN_MSB = 7;
  localparam int LAST_CHAN_LSB = 3;
  localparam int DUPLEX_BIT    = 2;

  typedef logic [4:0] chan_t;

endpackage

// File: cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder import radio_cfg_pkg::*, radio_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic [CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [CMD_DATA_W-1:0] cmd_data_i,
  input  logic                  cmd_rqst_i,
  output logic                  cmd_ack_o,
  output logic                  freq_capture_o,
  output logic                  freq_commit_o,
  output logic                  duplex_o,
  output chan_t                 last_chan_o,
  output logic                  vna_o,
  output rate_t                 rx_rate_o
);

  cmd_state_e                  state_q;
  logic [RATE_MSB-RATE_LSB:0]  rate_code_q;

  // Command FSM and control registers
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= CMD_IDLE;
      rate_code_q <= '0;
      duplex_o    <= 1'b0;
      last_chan_o <= '0;
      vna_o       <= 1'b0;
    end else begin
      case (state_q)
        CMD_IDLE: begin
          if (cmd_rqst_i) begin
            case (cmd_addr_i)
              // Frequency writes run through the multiply pipeline
              CMD_TX_FREQ, CMD_RX0_FREQ, CMD_RX1_FREQ, CMD_RX2_FREQ, CMD_RX3_FREQ:
                state_q <= CMD_FREQ1;
              // Control words take effect at once, no ack
              CMD_CTRL: begin
                rate_code_q <= cmd_data_i[RATE_MSB:RATE_LSB];
                last_chan_o <= cmd_data_i[LAST_CHAN_MSB:LAST_CHAN_LSB];
                duplex_o    <= cmd_data_i[DUPLEX_BIT];
              end
              CMD_VNA: vna_o <= cmd_data_i[VNA_BIT];
              // Unknown addresses are dropped
              default: state_q <= CMD_IDLE;
            endcase
          end
        end
        CMD_FREQ1: state_q <= CMD_FREQ2;
        CMD_FREQ2: state_q <= CMD_FREQ3;
        default:   state_q <= CMD_IDLE;
      endcase
    end
  end

  // Capture the product one cycle before commit
  assign freq_capture_o = (state_q == CMD_FREQ2);
  assign freq_commit_o  = (state_q == CMD_FREQ3);
  // Ack coincides with commit
  assign cmd_ack_o      = (state_q == CMD_FREQ3);

  // Decimation halves for every rate step
  assign rx_rate_o = RATE48 >> rate_code_q;

endmodule

// File: tuning_regs.sv
`timescale 1ns/1ps

module tuning_regs import radio_cfg_pkg::*, radio_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic [CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [CMD_DATA_W-1:0] cmd_data_i,
  input  logic                  freq_capture_i,
  input  logic                  freq_commit_i,
  input  logic                  duplex_i,
  input  chan_t                 last_chan_i,
  output phase_word_t           tx_phase_o,
  output phase_word_t           rx_phase_o [NUM_RX]
);

  logic [63:0]           freq_prod;
  phase_word_t           phase_cap_q;
  logic [CMD_ADDR_W-1:0] addr_cap_q;
  logic                  single_rx;

  // Rounded frequency times 2^57 over the clock
  assign freq_prod = cmd_data_i * FREQ_MULT + FREQ_ROUND;

  // Simplex with one receiver makes RX0 track the TX phase
  assign single_rx = !duplex_i && (last_chan_i == '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_cap_q <= '0;
      addr_cap_q  <= '0;
      tx_phase_o  <= '0;
      rx_phase_o  <= '{default: '0};
    end else begin
      // Multiply has had two cycles to settle
      if (freq_capture_i) begin
        phase_cap_q <= freq_prod[FREQ_MSB:FREQ_LSB];
        addr_cap_q  <= cmd_addr_i;
      end
      if (freq_commit_i) begin
        if (addr_cap_q == CMD_TX_FREQ) begin
          tx_phase_o <= phase_cap_q;
          if (single_rx) rx_phase_o[0] <= phase_cap_q;
        end
        if (addr_cap_q == CMD_RX0_FREQ) begin
          rx_phase_o[0] <= single_rx ? tx_phase_o : phase_cap_q;
        end
        // Remaining receivers sit on consecutive addresses
        for (int i = 1; i < NUM_RX; i++) begin
          if (addr_cap_q == CMD_ADDR_W'(int'(CMD_RX0_FREQ) + i)) rx_phase_o[i] <= phase_cap_q;
        end
      end
    end
  end

endmodule

// File: cw_keyer.sv
`timescale 1ns/1ps

module cw_keyer import radio_cfg_pkg::*; (
  input  logic      clk,
  input  logic      arst_n_i,
  input  logic      cw_keydown_i,
  output logic      tx_cw_key_o,
  output cw_level_t cw_level_o
);

  cw_state_e state_q;

  // Linear rise and fall of one step per clock
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= CW_RX;
      cw_level_o <= '0;
    end else begin
      case (state_q)
        CW_RX: begin
          cw_level_o <= '0;
          if (cw_keydown_i) state_q <= CW_RISE;
        end
        CW_RISE: begin
          // Hold at full carrier
          if (cw_level_o != MAX_CW_LEVEL) cw_level_o <= cw_level_o + 1'b1;
          if (!cw_keydown_i) state_q <= CW_FALL;
        end
        default: begin
          // Ramp down, back to receive at zero
          if (cw_level_o == '0) state_q <= CW_RX;
          else cw_level_o <= cw_level_o - 1'b1;
        end
      endcase
    end
  end

  // Carrier is keyed until the ramp has fully decayed
  assign tx_cw_key_o = (state_q != CW_RX);

endmodule

// File: tx_baseband.sv
`timescale 1ns/1ps

module tx_baseband import radio_cfg_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic [2*SAMPLE_W-1:0] tx_tdata_i,
  input  logic                  tx_tvalid_i,
  output logic                  tx_tready_o,
  input  logic                  tx_sample_req_i,
  input  logic                  vna_i,
  input  logic                  tx_cw_key_i,
  input  cw_level_t             cw_level_i,
  output tx_sample_t            tx_i_o,
  output tx_sample_t            tx_q_o
);

  tx_sample_t hold_i_q;
  tx_sample_t hold_q_q;
  logic       full_q;
  logic       xfer;

  // Single sample buffer, ready while empty
  assign tx_tready_o = !full_q;
  assign xfer        = tx_tvalid_i && tx_tready_o;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_i_q <= '0;
      hold_q_q <= '0;
      full_q   <= 1'b0;
      tx_i_o   <= '0;
      tx_q_o   <= '0;
    end else begin
      // I in the upper half, Q in the lower half
      if (xfer) begin
        hold_i_q <= tx_tdata_i[2*SAMPLE_W-1:SAMPLE_W];
        hold_q_q <= tx_tdata_i[SAMPLE_W-1:0];
      end
      // A request drains the buffer unless a sample lands the same cycle
      if (xfer) full_q <= 1'b1;
      else if (tx_sample_req_i) full_q <= 1'b0;
      // VNA over CW over stream data, updated on request only
      if (tx_sample_req_i) begin
        if (vna_i) begin
          tx_i_o <= tx_sample_t'(VNA_LEVEL);
          tx_q_o <= '0;
        end else if (tx_cw_key_i) begin
          tx_i_o <= {1'b0, cw_level_i[18:4]};
          tx_q_o <= '0;
        end else begin
          tx_i_o <= full_q ? hold_i_q : '0;
          tx_q_o <= full_q ? hold_q_q : '0;
        end
      end
    end
  end

endmodule

// File: rx_upstream.sv
`timescale 1ns/1ps

module rx_upstream import radio_cfg_pkg::*, radio_cmd_pkg::*; (
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     rx_strobe_i,
  input  rx_word_t rx_i_i [NUM_RX],
  input  rx_word_t rx_q_i [NUM_RX],
  input  chan_t    last_chan_i,
  output rx_word_t rx_tdata_o,
  output logic     rx_tvalid_o,
  input  logic     rx_tready_i,
  output logic     rx_tlast_o,
  output logic [1:0] rx_tuser_o
);

  rxus_state_e state_q;
  chan_t       chan_q;
  chan_t       frame_last_q;
  chan_t       last_clamped;
  rx_word_t    snap_i_q [NUM_RX];
  rx_word_t    snap_q_q [NUM_RX];

  // Never address past the last receiver
  assign last_clamped = (last_chan_i > chan_t'(NUM_RX - 1)) ? chan_t'(NUM_RX - 1) : last_chan_i;

  // --------------------------------------------------
  // Frame sequencing
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= RXUS_IDLE;
      chan_q       <= '0;
      frame_last_q <= '0;
      snap_i_q     <= '{default: '0};
      snap_q_q     <= '{default: '0};
    end else begin
      case (state_q)
        RXUS_IDLE: begin
          // Strobes are only seen here, so mid-frame ones drop
          if (rx_strobe_i) begin
            snap_i_q     <= rx_i_i;
            snap_q_q     <= rx_q_i;
            chan_q       <= '0;
            frame_last_q <= last_clamped;
            state_q      <= RXUS_I;
          end
        end
        RXUS_I: if (rx_tready_i) state_q <= RXUS_Q;
        default: begin
          if (rx_tready_i) begin
            if (chan_q == frame_last_q) begin
              state_q <= RXUS_IDLE;
            end else begin
              chan_q  <= chan_q + 1'b1;
              state_q <= RXUS_I;
            end
          end
        end
      endcase
    end
  end

  // Outputs follow registered state so they hold under back-pressure
  always_comb begin
    case (state_q)
      RXUS_I:  rx_tdata_o = snap_i_q[chan_q[$clog2(NUM_RX)-1:0]];
      RXUS_Q:  rx_tdata_o = snap_q_q[chan_q[$clog2(NUM_RX)-1:0]];
      default: rx_tdata_o = '0;
    endcase
  end

  assign rx_tvalid_o = (state_q != RXUS_IDLE);
  assign rx_tlast_o  = (state_q == RXUS_Q) && (chan_q == frame_last_q);
  assign rx_tuser_o  = 2'b00;

endmodule

// File: radio_core.sv
`timescale 1ns/1ps

module radio_core import radio_cfg_pkg::*, radio_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n_i,
  // Key and carrier state
  input  logic                  cw_keydown_i,
  output logic                  tx_cw_key_o,
  // Command slave
  input  logic [CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [CMD_DATA_W-1:0] cmd_data_i,
  input  logic                  cmd_rqst_i,
  output logic                  cmd_ack_o,
  // Tuning to the external NCOs and receivers
  output phase_word_t           tx_phase_o,
  output phase_word_t           rx_phase_o [NUM_RX],
  output rate_t                 rx_rate_o,
  // TX sample stream and interpolator side
  input  logic [2*SAMPLE_W-1:0] tx_tdata_i,
  input  logic                  tx_tvalid_i,
  output logic                  tx_tready_o,
  input  logic                  tx_sample_req_i,
  output tx_sample_t            tx_i_o,
  output tx_sample_t            tx_q_o,
  // Receiver samples and upstream stream
  input  logic                  rx_strobe_i,
  input  rx_word_t              rx_i_i [NUM_RX],
  input  rx_word_t              rx_q_i [NUM_RX],
  output rx_word_t              rx_tdata_o,
  output logic                  rx_tvalid_o,
  input  logic                  rx_tready_i,
  output logic                  rx_tlast_o,
  output logic [1:0]            rx_tuser_o
);

  logic      freq_capture;
  logic      freq_commit;
  logic      duplex;
  chan_t     last_chan;
  logic      vna;
  cw_level_t cw_level;

  // --------------------------------------------------
  // Control path
  // --------------------------------------------------
  cmd_decoder u_cmd_decoder (
    .clk, .arst_n_i, .cmd_addr_i, .cmd_data_i, .cmd_rqst_i, .cmd_ack_o,
    .freq_capture_o(freq_capture), .freq_commit_o(freq_commit),
    .duplex_o(duplex), .last_chan_o(last_chan), .vna_o(vna), .rx_rate_o
  );

  tuning_regs u_tuning_regs (
    .clk, .arst_n_i, .cmd_addr_i, .cmd_data_i,
    .freq_capture_i(freq_capture), .freq_commit_i(freq_commit),
    .duplex_i(duplex), .last_chan_i(last_chan), .tx_phase_o, .rx_phase_o
  );

  // --------------------------------------------------
  // Transmit and receive data paths
  // --------------------------------------------------
  cw_keyer u_cw_keyer (
    .clk, .arst_n_i, .cw_keydown_i, .tx_cw_key_o, .cw_level_o(cw_level)
  );

  tx_baseband u_tx_baseband (
    .clk, .arst_n_i, .tx_tdata_i, .tx_tvalid_i, .tx_tready_o, .tx_sample_req_i,
    .vna_i(vna), .tx_cw_key_i(tx_cw_key_o), .cw_level_i(cw_level), .tx_i_o, .tx_q_o
  );

  rx_upstream u_rx_upstream (
    .clk, .arst_n_i, .rx_strobe_i, .rx_i_i, .rx_q_i, .last_chan_i(last_chan),
    .rx_tdata_o, .rx_tvalid_o, .rx_tready_i, .rx_tlast_o, .rx_tuser_o
  );

endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held over the first three rising edges
  initial begin
    arst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

// File: radio_core_chk.sv
`timescale 1ns/1ps

module radio_core_chk import radio_cfg_pkg::*; (
  input logic      clk,
  input logic      arst_n_i,
  input logic      cmd_ack_i,
  input rx_word_t  rx_tdata_i,
  input logic      rx_tvalid_i,
  input logic      rx_tready_i,
  input logic      rx_tlast_i,
  input logic      tx_cw_key_i,
  input cw_level_t cw_level_i
);

  // Ack is a single-cycle pulse
  ack_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
    cmd_ack_i |=> !cmd_ack_i)
    else $error("cmd_ack_o high for more than one cycle");

  // Upstream beat must hold while stalled
  rx_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    (rx_tvalid_i && !rx_tready_i) |=>
      (rx_tvalid_i && $stable(rx_tdata_i) && $stable(rx_tlast_i)))
    else $error("rx stream beat changed under back-pressure");

  // Key only drops once the ramp has fully decayed
  key_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
    !tx_cw_key_i |-> (cw_level_i == '0))
    else $error("tx_cw_key_o low while the CW level is not zero");

endmodule

bind radio_core radio_core_chk u_chk (
  .clk, .arst_n_i, .cmd_ack_i(cmd_ack_o),
  .rx_tdata_i(rx_tdata_o), .rx_tvalid_i(rx_tvalid_o), .rx_tready_i(rx_tready_i),
  .rx_tlast_i(rx_tlast_o), .tx_cw_key_i(tx_cw_key_o),
  .cw_level_i(cw_level)
);

// File: tb_radio_core.sv
`timescale 1ns/1ps

module tb_radio_core import radio_cfg_pkg::*; ();

  // --------------------------------------------------
  // Constants of the reference model
  // --------------------------------------------------
  localparam int          CW_STEPS    = 'h4d800;
  localparam logic [18:0] CW_MAX      = 19'h4d800;
  localparam logic [15:0] VNA_I       = 16'h4d80;
  localparam int          N_FREQ      = 40;
  localparam int          N_CTRL      = 6;
  localparam int          N_FRAMES    = 20;
  localparam int          N_TX        = 3000;
  localparam int          FRAME_LIMIT = 200;
  // Dominated by the full CW rise and fall
  localparam int TIMEOUT_CYC = 2 * CW_STEPS + N_TX + 400 + N_FREQ * 12
                             + (N_CTRL + N_FRAMES) * (FRAME_LIMIT + 4) + 5000;

  logic        clk;
  logic        arst_n_i;
  logic        cw_keydown_i;
  logic        tx_cw_key_o;
  logic [5:0]  cmd_addr_i;
  logic [31:0] cmd_data_i;
  logic        cmd_rqst_i;
  logic        cmd_ack_o;
  phase_word_t tx_phase_o;
  phase_word_t rx_phase_o [NUM_RX];
  rate_t       rx_rate_o;
  logic [31:0] tx_tdata_i;
  logic        tx_tvalid_i;
  logic        tx_tready_o;
  logic        tx_sample_req_i;
  tx_sample_t  tx_i_o;
  tx_sample_t  tx_q_o;
  logic        rx_strobe_i;
  rx_word_t    rx_i_i [NUM_RX];
  rx_word_t    rx_q_i [NUM_RX];
  rx_word_t    rx_tdata_o;
  logic        rx_tvalid_o;
  logic        rx_tready_i;
  logic        rx_tlast_o;
  logic [1:0]  rx_tuser_o;

  // Model state
  logic [31:0] lcg_q;
  logic [31:0] m_tx_ph;
  logic [31:0] m_rx_ph [NUM_RX];
  logic        m_duplex;
  logic [4:0]  m_last;
  logic        m_vna;
  logic        m_full;
  logic [15:0] m_hold_i;
  logic [15:0] m_hold_q;
  logic [15:0] m_exp_i;
  logic [15:0] m_exp_q;
  cw_state_e   m_cw;
  logic [18:0] m_lvl;
  int          err_cnt;
  int          chk_cnt;

  tb_clkgen u_clkgen (.clk_o(clk), .arst_n_o(arst_n_i));

  radio_core dut (.*);

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
    return lcg_q;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = next_rand();
    return r[31];
  endfunction

  // Frequency times 2^57 over 76.8 MHz, rounded, bits 56:25
  function automatic logic [31:0] phase_of(logic [31:0] f);
    logic [63:0] p;
    p = {32'd0, f} * 64'd1876499845 + 64'd16777216;
    return p[56:25];
  endfunction

  task automatic report_error(string what);
    err_cnt++;
    $display("Error at time %0t: %s", $time, what);
  endtask

  task automatic check_eq(string name, logic [63:0] got, logic [63:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("Mismatch at time %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic end_test(string name, int base);
    $display("%-12s %s (%0d errors)", name, (err_cnt == base) ? "ok" : "FAILED",
             err_cnt - base);
  endtask

  // --------------------------------------------------
  // Command port
  // --------------------------------------------------
  task automatic send_ctrl(logic [1:0] rate, logic [4:0] last, logic dup);
    logic [31:0] d;
    d = next_rand();
    d[25:24] = rate;
    d[23] = 1'b0;
    d[7:3] = last;
    d[2] = dup;
    @(posedge clk);
    #1;
    cmd_addr_i = 6'h00;
    cmd_data_i = d;
    cmd_rqst_i = 1'b1;
    // Taken at the next edge, request dropped right after
    @(posedge clk);
    #1;
    cmd_rqst_i = 1'b0;
    m_last = last;
    m_duplex = dup;
    repeat (4) begin
      @(negedge clk);
      assert (!cmd_ack_o) else report_error("cmd_ack_o raised on a control write");
    end
    check_eq("rx_rate_o", rx_rate_o, 6'd40 >> rate);
  endtask

  task automatic random_ctrl();
    logic [31:0] r;
    r = next_rand();
    // Bias towards last_chan 0 to exercise the RX0 tracking path
    send_ctrl(r[25:24], r[31] ? 5'd0 : {2'b00, r[30:28]}, r[27]);
  endtask

  task automatic send_vna(logic v);
    @(posedge clk);
    #1;
    cmd_addr_i = 6'h09;
    cmd_data_i = {8'h00, v, 23'h0};
    cmd_rqst_i = 1'b1;
    @(posedge clk);
    #1;
    cmd_rqst_i = 1'b0;
    m_vna = v;
  endtask

  task automatic send_freq(logic [5:0] addr, logic [31:0] f);
    int          n;
    logic [31:0] p;
    logic        single;
    @(posedge clk);
    #1;
    cmd_addr_i = addr;
    cmd_data_i = f;
    cmd_rqst_i = 1'b1;
    // Edge that accepts the request
    @(posedge clk);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!cmd_ack_o && n < 10);
    assert (cmd_ack_o) else report_error("no cmd_ack_o on a frequency write");
    check_eq("cmd_ack_o latency", n, 3);
    @(posedge clk);
    #1;
    cmd_rqst_i = 1'b0;
    // Routing rule
    p = phase_of(f);
    single = !m_duplex && (m_last == 5'd0);
    case (addr)
      6'h01: begin
        m_tx_ph = p;
        if (single) m_rx_ph[0] = p;
      end
      6'h02: m_rx_ph[0] = single ? m_tx_ph : p;
      default: m_rx_ph[addr - 6'h02] = p;
    endcase
    @(negedge clk);
    check_eq("cmd_ack_o", cmd_ack_o, 1'b0);
    check_eq("tx_phase_o", tx_phase_o, m_tx_ph);
    for (int c = 0; c < NUM_RX; c++) begin
      check_eq($sformatf("rx_phase_o[%0d]", c), rx_phase_o[c], m_rx_ph[c]);
    end
  endtask

  // --------------------------------------------------
  // Upstream frames
  // --------------------------------------------------
  task automatic run_frame();
    rx_word_t snap_i [NUM_RX];
    rx_word_t snap_q [NUM_RX];
    int       last;
    int       total;
    int       idx;
    int       cyc;
    logic     fin;
    last = (m_last > 5'd3) ? 3 : int'(m_last);
    total = 2 * (last + 1);
    @(posedge clk);
    #1;
    for (int c = 0; c < NUM_RX; c++) begin
      rx_i_i[c] = rx_word_t'(next_rand());
      rx_q_i[c] = rx_word_t'(next_rand());
      snap_i[c] = rx_i_i[c];
      snap_q[c] = rx_q_i[c];
    end
    rx_strobe_i = 1'b1;
    rx_tready_i = rand_bit();
    idx = 0;
    cyc = 0;
    while (idx < total && cyc < FRAME_LIMIT) begin
      @(negedge clk);
      cyc++;
      fin = 1'b0;
      if (rx_tvalid_o && rx_tready_i) begin
        check_eq("rx_tdata_o", rx_tdata_o, (idx % 2 == 0) ? snap_i[idx / 2] : snap_q[idx / 2]);
        check_eq("rx_tlast_o", rx_tlast_o, idx == total - 1);
        check_eq("rx_tuser_o", rx_tuser_o, 2'b00);
        idx++;
        fin = (idx == total);
      end
      @(posedge clk);
      #1;
      rx_tready_i = rand_bit();
      // Mid-frame strobes with fresh inputs must be ignored
      rx_strobe_i = fin ? 1'b0 : rand_bit();
      for (int c = 0; c < NUM_RX; c++) begin
        rx_i_i[c] = rx_word_t'(next_rand());
        rx_q_i[c] = rx_word_t'(next_rand());
      end
    end
    rx_strobe_i = 1'b0;
    assert (idx == total) else report_error("RX frame did not complete in time");
    @(negedge clk);
    check_eq("rx_tvalid_o", rx_tvalid_o, 1'b0);
  endtask

  // --------------------------------------------------
  // One cycle of TX stream and keyer
  // --------------------------------------------------
  task automatic tx_cycle(logic v, logic [31:0] d, logic req, logic key);
    logic xfer;
    @(posedge clk);
    #1;
    tx_tvalid_i = v;
    tx_tdata_i = d;
    tx_sample_req_i = req;
    cw_keydown_i = key;
    @(negedge clk);
    check_eq("tx_i_o", $unsigned(tx_i_o), m_exp_i);
    check_eq("tx_q_o", $unsigned(tx_q_o), m_exp_q);
    check_eq("tx_tready_o", tx_tready_o, !m_full);
    check_eq("tx_cw_key_o", tx_cw_key_o, m_cw != CW_RX);
    // Advance the model to the coming edge
    xfer = v && !m_full;
    if (req) begin
      if (m_vna) begin
        m_exp_i = VNA_I;
        m_exp_q = '0;
      end else if (m_cw != CW_RX) begin
        m_exp_i = {1'b0, m_lvl[18:4]};
        m_exp_q = '0;
      end else begin
        m_exp_i = m_full ? m_hold_i : '0;
        m_exp_q = m_full ? m_hold_q : '0;
      end
    end
    if (xfer) begin
      m_hold_i = d[31:16];
      m_hold_q = d[15:0];
      m_full = 1'b1;
    end else if (req) begin
      m_full = 1'b0;
    end
    case (m_cw)
      CW_RX: begin
        m_lvl = '0;
        if (key) m_cw = CW_RISE;
      end
      CW_RISE: begin
        if (m_lvl != CW_MAX) m_lvl = m_lvl + 1'b1;
        if (!key) m_cw = CW_FALL;
      end
      default: begin
        if (m_lvl == '0) m_cw = CW_RX;
        else m_lvl = m_lvl - 1'b1;
      end
    endcase
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    int          base;
    logic [31:0] r;
    lcg_q = 32'h325bccae;
    err_cnt = 0;
    chk_cnt = 0;
    cw_keydown_i = 1'b0;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    cmd_rqst_i = 1'b0;
    tx_tdata_i = '0;
    tx_tvalid_i = 1'b0;
    tx_sample_req_i = 1'b0;
    rx_strobe_i = 1'b0;
    rx_tready_i = 1'b0;
    for (int c = 0; c < NUM_RX; c++) begin
      rx_i_i[c] = '0;
      rx_q_i[c] = '0;
      m_rx_ph[c] = '0;
    end
    // Model matches the reset state
    m_tx_ph = '0;
    m_duplex = 1'b0;
    m_last = '0;
    m_vna = 1'b0;
    m_full = 1'b0;
    m_hold_i = '0;
    m_hold_q = '0;
    m_exp_i = '0;
    m_exp_q = '0;
    m_cw = CW_RX;
    m_lvl = '0;
    wait (arst_n_i === 1'b1);
    repeat (2) @(posedge clk);

    // Frequency writes under random routing modes
    base = err_cnt;
    for (int k = 0; k < N_FREQ; k++) begin
      if (k % 5 == 0) random_ctrl();
      r = next_rand();
      send_freq(6'(1 + (r >> 8) % 5), next_rand());
    end
    end_test("freq_writes", base);

    // Control writes, each followed by a frame
    base = err_cnt;
    for (int k = 0; k < N_CTRL; k++) begin
      random_ctrl();
      run_frame();
    end
    end_test("ctrl_writes", base);

    base = err_cnt;
    for (int k = 0; k < N_FRAMES; k++) run_frame();
    end_test("rx_frames", base);

    // TX stream with random valid and requests
    base = err_cnt;
    for (int k = 0; k < N_TX; k++) begin
      r = next_rand();
      tx_cycle(r[31], next_rand(), r[30], 1'b0);
    end
    tx_cycle(1'b0, '0, 1'b0, 1'b0);
    end_test("tx_stream", base);

    // Key held past full carrier, then released to idle
    base = err_cnt;
    for (int k = 0; k < CW_STEPS + 64; k++) begin
      r = next_rand();
      tx_cycle(r[31], next_rand(), r[30] & r[29], 1'b1);
    end
    while (m_cw != CW_RX) begin
      r = next_rand();
      tx_cycle(r[31], next_rand(), r[30] & r[29], 1'b0);
    end
    repeat (16) begin
      r = next_rand();
      tx_cycle(r[31], next_rand(), r[30], 1'b0);
    end
    tx_cycle(1'b0, '0, 1'b0, 1'b0);
    end_test("cw_ramp", base);

    // VNA level overrides the stream
    base = err_cnt;
    send_vna(1'b1);
    repeat (200) begin
      r = next_rand();
      tx_cycle(r[31], next_rand(), r[30], 1'b0);
    end
    tx_cycle(1'b0, '0, 1'b0, 1'b0);
    send_vna(1'b0);
    repeat (50) begin
      r = next_rand();
      tx_cycle(r[31], next_rand(), r[30], 1'b0);
    end
    tx_cycle(1'b0, '0, 1'b0, 1'b0);
    end_test("vna_level", base);

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog on total run length
  initial begin
    int cyc;
    cyc = 0;
    while (cyc < TIMEOUT_CYC) begin
      @(posedge clk);
      cyc++;
    end
    $display("Timeout, run exceeded %0d cycles", TIMEOUT_CYC);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: list.f
radio_cfg_pkg.sv
radio_cmd_pkg.sv
cmd_decoder.sv
tuning_regs.sv
cw_keyer.sv
tx_baseband.sv
rx_upstream.sv
radio_core.sv
tb_clkgen.sv
radio_core_chk.sv
tb_radio_core.sv

// File: Makefile
TOP = tb_radio_core

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
